// ==== verilog.f ====
logic/rvPkg.sv
logic/pipeReg.sv
logic/fetchStage.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/rvCore.sv
verif/rvCore_chk.sv
verif/rvCoreTb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - logic/rvPkg.sv
      - logic/pipeReg.sv
      - logic/fetchStage.sv
      - logic/regFile.sv
      - logic/decodeStage.sv
      - logic/executeStage.sv
      - logic/memWbStage.sv
      - logic/rvCore.sv
  - target: simulation
    files:
      - verif/rvCore_chk.sv
      - verif/rvCoreTb.sv

// ==== verif/rvCoreTb.sv ====
// RV32I core testbench
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb
	import rvPkg::*;
();

	localparam int CLK_PERIOD     = 40;
	localparam int PROG_LEN       = 36;
	localparam int NUM_STORES     = 13;
	localparam int TIMEOUT_CYCLES = 4 * PROG_LEN + 40;

	typedef struct packed {
		word_t addr;
		word_t data;
	} storeEntry_t;

	logic  clk;
	logic  rst_n;
	word_t imemAddr;
	word_t imemData;
	logic  dmemRead;
	logic  dmemWrite;
	word_t dmemAddr;
	word_t dmemWdata;
	word_t dmemRdata;

	word_t       progRom [PROG_LEN];
	word_t       dataRam [0:127];
	storeEntry_t expStores [NUM_STORES];
	int          cycleCount = 0;
	int          errorCount = 0;
	int          missingStores;

	rvCore u_rvCore (
		.clk      (clk),
		.rst_n    (rst_n),
		.imemAddr (imemAddr),
		.imemData (imemData),
		.dmemRead (dmemRead),
		.dmemWrite(dmemWrite),
		.dmemAddr (dmemAddr),
		.dmemWdata(dmemWdata),
		.dmemRdata(dmemRdata)
	);

	bind rvCore rvCoreChk u_rvCoreChk (
		.clk      (clk),
		.rst_n    (rst_n),
		.imemAddr (imemAddr),
		.dmemRead (dmemRead),
		.dmemWrite(dmemWrite),
		.dmemAddr (dmemAddr)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	// ======================================================================
	// Memory models
	// ======================================================================
	assign imemData = (imemAddr[31:2] < PROG_LEN) ? progRom[imemAddr[31:2]] : NOP_INST;
	// Same-cycle read, data only while the read strobe is high
	assign dmemRdata = dmemRead ? dataRam[dmemAddr[8:2]] : '0;

	always @(posedge clk) begin
		if (dmemWrite) begin
			dataRam[dmemAddr[8:2]] <= dmemWdata;
		end
	end

	// ======================================================================
	// Instruction encoders
	// ======================================================================
	function automatic word_t aluReg(logic [6:0] f7, logic [2:0] f3, regAddr_t rd,
	                                 regAddr_t rs1, regAddr_t rs2);
		return {f7, rs2, rs1, f3, rd, OP_RTYPE};
	endfunction

	function automatic word_t aluImm(logic [2:0] f3, regAddr_t rd, regAddr_t rs1,
	                                 logic [11:0] imm);
		return {imm, rs1, f3, rd, OP_ITYPE};
	endfunction

	function automatic word_t loadWord(regAddr_t rd, regAddr_t rs1, logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, OP_LOAD};
	endfunction

	function automatic word_t storeWord(regAddr_t rs2, regAddr_t rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic word_t branchTo(logic [2:0] f3, regAddr_t rs1, regAddr_t rs2,
	                                   logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
	endfunction

	task automatic loadProgram();
		progRom[0]  = aluImm(3'b000, 5'd1, 5'd0, 12'h123);       // addi x1 = 0x123
		progRom[1]  = aluImm(3'b000, 5'd2, 5'd0, 12'hFF8);       // addi x2 = -8
		progRom[2]  = aluReg(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);   // add
		progRom[3]  = aluReg(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);   // sub
		progRom[4]  = aluImm(3'b001, 5'd5, 5'd3, 12'h004);       // slli
		progRom[5]  = aluReg(7'h00, 3'b010, 5'd6, 5'd4, 5'd1);   // slt
		progRom[6]  = aluReg(7'h00, 3'b100, 5'd7, 5'd5, 5'd4);   // xor
		progRom[7]  = aluImm(3'b101, 5'd8, 5'd7, 12'h008);       // srli
		progRom[8]  = aluImm(3'b101, 5'd9, 5'd7, 12'h404);       // srai
		progRom[9]  = aluReg(7'h00, 3'b110, 5'd10, 5'd8, 5'd6);  // or
		progRom[10] = aluReg(7'h00, 3'b111, 5'd11, 5'd10, 5'd9); // and
		for (int r = 3; r <= 11; r++) begin
			progRom[r + 8] = storeWord(regAddr_t'(r), 5'd0, 12'(12'h100 + (r - 3) * 4));
		end
		// Load-use pair
		progRom[20] = loadWord(5'd12, 5'd0, 12'h040);
		progRom[21] = aluReg(7'h00, 3'b000, 5'd13, 5'd12, 5'd1);
		progRom[22] = storeWord(5'd13, 5'd0, 12'h124);
		// Branches, each right behind its operand producer
		progRom[23] = aluImm(3'b000, 5'd14, 5'd0, 12'h005);
		progRom[24] = aluImm(3'b000, 5'd15, 5'd0, 12'h005);
		progRom[25] = branchTo(3'b000, 5'd14, 5'd15, 13'd8);   // beq taken
		progRom[26] = storeWord(5'd1, 5'd0, 12'h128);          // Skipped
		progRom[27] = branchTo(3'b001, 5'd14, 5'd15, 13'd8);   // bne not taken
		progRom[28] = storeWord(5'd14, 5'd0, 12'h128);
		progRom[29] = loadWord(5'd16, 5'd0, 12'h044);
		progRom[30] = branchTo(3'b001, 5'd16, 5'd0, 13'd8);    // bne taken after load
		progRom[31] = storeWord(5'd1, 5'd0, 12'h12C);          // Skipped
		progRom[32] = storeWord(5'd16, 5'd0, 12'h12C);
		progRom[33] = aluImm(3'b000, 5'd0, 5'd0, 12'h055);     // Write to x0
		progRom[34] = storeWord(5'd0, 5'd0, 12'h130);
		progRom[35] = branchTo(3'b000, 5'd0, 5'd0, 13'd0);     // Spin here
	endtask

	task automatic loadExpected();
		expStores[0]  = '{addr: 32'h100, data: 32'h0000_011B};
		expStores[1]  = '{addr: 32'h104, data: 32'hFFFF_FFF8};
		expStores[2]  = '{addr: 32'h108, data: 32'h0000_11B0};
		expStores[3]  = '{addr: 32'h10C, data: 32'h0000_0001};
		expStores[4]  = '{addr: 32'h110, data: 32'hFFFF_EE48};
		expStores[5]  = '{addr: 32'h114, data: 32'h00FF_FFEE};
		expStores[6]  = '{addr: 32'h118, data: 32'hFFFF_FEE4};
		expStores[7]  = '{addr: 32'h11C, data: 32'h00FF_FFEF};
		expStores[8]  = '{addr: 32'h120, data: 32'h00FF_FEE4};
		expStores[9]  = '{addr: 32'h124, data: 32'hD000_0163};
		expStores[10] = '{addr: 32'h128, data: 32'h0000_0005};
		expStores[11] = '{addr: 32'h12C, data: 32'hD000_0044};
		expStores[12] = '{addr: 32'h130, data: 32'h0000_0000};
	endtask

	// Each word holds its own byte address above a marker
	task automatic fillDataRam();
		for (int i = 0; i < 128; i++) begin
			dataRam[i] = 32'hD000_0000 + (i << 2);
		end
	endtask

	task automatic waitForStore(output logic seen);
		seen = 1'b0;
		while (!seen && (cycleCount < TIMEOUT_CYCLES)) begin
			@(negedge clk);
			seen = dmemWrite;
		end
	endtask

	always @(negedge clk) begin
		if (!rst_n) begin
			assert (!dmemRead && !dmemWrite) else begin
				$display("Data memory strobe active during reset at cycle %0d", cycleCount);
				errorCount++;
			end
		end
	end

	// ======================================================================
	// Main sequence
	// ======================================================================
	initial begin
		int   idx;
		int   chkFails;
		logic seen;

		clk   = 1'b0;
		rst_n = 1'b0;
		loadProgram();
		loadExpected();
		fillDataRam();

		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (imemAddr == 32'h0) else begin
			$display("ERR imemAddr: got %h expected %h", imemAddr, 32'h0);
			errorCount++;
		end

		idx  = 0;
		seen = 1'b1;
		while (seen && (idx < NUM_STORES)) begin
			waitForStore(seen);
			if (seen) begin
				assert (dmemAddr == expStores[idx].addr) else begin
					$display("ERR dmemAddr store %0d: got %h expected %h",
					         idx, dmemAddr, expStores[idx].addr);
					errorCount++;
				end
				assert (dmemWdata == expStores[idx].data) else begin
					$display("ERR dmemWdata store %0d: got %h expected %h",
					         idx, dmemWdata, expStores[idx].data);
					errorCount++;
				end
				idx++;
			end
		end

		// Let the bound assertions see the last store cycle
		@(negedge clk);

		missingStores = NUM_STORES - idx;
		assert (missingStores == 0) else begin
			$display("Timeout after %0d cycles, only %0d of %0d stores were seen",
			         cycleCount, idx, NUM_STORES);
		end

		chkFails = u_rvCore.u_rvCoreChk.failCount;
		$display("Check errors: %0d, assertion failures: %0d, missing stores: %0d",
		         errorCount, chkFails, missingStores);
		if ((errorCount == 0) && (chkFails == 0) && (missingStores == 0)) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/rvCore_chk.sv ====
// Memory port assertions
`timescale 1ns/1ps
`default_nettype none

module rvCoreChk
	import rvPkg::*;
(
	input logic  clk,
	input logic  rst_n,
	input word_t imemAddr,
	input logic  dmemRead,
	input logic  dmemWrite,
	input word_t dmemAddr
);

	int failCount = 0; // Failed assertions so far

	// One data access per cycle
	assert property (@(posedge clk) disable iff (!rst_n) !(dmemRead && dmemWrite))
	else begin
		$error("Data read and write strobes high in the same cycle");
		failCount++;
	end

	assert property (@(negedge clk) !rst_n |-> (!dmemRead && !dmemWrite))
	else begin
		$error("Data strobe high while reset is asserted");
		failCount++;
	end

	// First cycle out of reset
	assert property (@(posedge clk) $rose(rst_n) |-> (!dmemRead && !dmemWrite))
	else begin
		$error("Data strobe high in the first cycle after reset");
		failCount++;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(dmemRead || dmemWrite) |-> ((dmemAddr[1:0] == 2'b00) && (imemAddr[1:0] == 2'b00)))
	else begin
		$error("Unaligned memory address during a data strobe");
		failCount++;
	end

endmodule

`default_nettype wire

// ==== logic/rvCore.sv ====
// Five-stage RV32I core
`timescale 1ns/1ps
`default_nettype none

module rvCore
	import rvPkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	output word_t imemAddr,
	input  word_t imemData,
	output logic  dmemRead,
	output logic  dmemWrite,
	output word_t dmemAddr,
	output word_t dmemWdata,
	input  word_t dmemRdata
);

	ifId_t   ifId;
	idEx_t   idEx;
	exMem_t  exMem;
	fwdSrc_t meFwd;
	fwdSrc_t wb;
	logic    stall;
	logic    redirect;
	word_t   redirectPc;

	// Memory stage offered for forwarding
	assign meFwd = '{regWrite: exMem.regWrite, rd: exMem.rd, data: exMem.aluResult};

	fetchStage u_fetchStage (
		.clk       (clk),
		.rst_n     (rst_n),
		.stall     (stall),
		.redirect  (redirect),
		.redirectPc(redirectPc),
		.imemData  (imemData),
		.imemAddr  (imemAddr),
		.ifId      (ifId)
	);

	decodeStage u_decodeStage (
		.clk       (clk),
		.rst_n     (rst_n),
		.ifId      (ifId),
		.meFwd     (meFwd),
		.wb        (wb),
		.exRd      (idEx.rd),
		.exCtrl    (idEx.ctrl),
		.meLoad    (exMem.memRead),
		.stall     (stall),
		.redirect  (redirect),
		.redirectPc(redirectPc),
		.idEx      (idEx)
	);

	executeStage u_executeStage (
		.clk  (clk),
		.rst_n(rst_n),
		.idEx (idEx),
		.meFwd(meFwd),
		.wb   (wb),
		.exMem(exMem)
	);

	memWbStage u_memWbStage (
		.clk      (clk),
		.rst_n    (rst_n),
		.exMem    (exMem),
		.dmemRdata(dmemRdata),
		.dmemRead (dmemRead),
		.dmemWrite(dmemWrite),
		.dmemAddr (dmemAddr),
		.dmemWdata(dmemWdata),
		.wb       (wb)
	);

endmodule

`default_nettype wire

// ==== logic/memWbStage.sv ====
// Memory access and writeback
`timescale 1ns/1ps
`default_nettype none

module memWbStage
	import rvPkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  exMem_t  exMem,
	input  word_t   dmemRdata,
	output logic    dmemRead,
	output logic    dmemWrite,
	output word_t   dmemAddr,
	output word_t   dmemWdata,
	output fwdSrc_t wb
);

	memWb_t memWbNext;
	memWb_t memWb;

	// Single-cycle strobes straight from the stage register
	assign dmemRead  = exMem.memRead;
	assign dmemWrite = exMem.memWrite;
	assign dmemAddr  = exMem.aluResult;
	assign dmemWdata = exMem.storeData;

	assign memWbNext = '{memToReg: exMem.memToReg, regWrite: exMem.regWrite,
	                     aluResult: exMem.aluResult, loadData: dmemRdata, rd: exMem.rd};

	pipeReg #(
		.T(memWb_t)
	) u_memWbReg (
		.clk   (clk),
		.rst_n (rst_n),
		.stall (1'b0),
		.bubble(1'b0),
		.d     (memWbNext),
		.q     (memWb)
	);

	assign wb = '{regWrite: memWb.regWrite, rd: memWb.rd,
	              data: memWb.memToReg ? memWb.loadData : memWb.aluResult};

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
// Execute stage with ALU
`timescale 1ns/1ps
`default_nettype none

module executeStage
	import rvPkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  idEx_t   idEx,
	input  fwdSrc_t meFwd,
	input  fwdSrc_t wb,
	output exMem_t  exMem
);

	word_t  opA;
	word_t  rs2Fwd;
	word_t  opB;
	word_t  aluResult;
	exMem_t exMemNext;

	// Memory stage result beats writeback data
	assign opA    = forwardOperand(idEx.rs1, idEx.rs1Data, meFwd, wb);
	assign rs2Fwd = forwardOperand(idEx.rs2, idEx.rs2Data, meFwd, wb);
	assign opB    = idEx.ctrl.aluSrc ? idEx.imm : rs2Fwd;

	always_comb begin
		case (idEx.ctrl.aluOp)
			ADD:     aluResult = opA + opB;
			SUB:     aluResult = opA - opB;
			SLL:     aluResult = opA << opB[4:0];
			SLT:     aluResult = {31'b0, $signed(opA) < $signed(opB)};
			XOR:     aluResult = opA ^ opB;
			SRL:     aluResult = opA >> opB[4:0];
			SRA:     aluResult = $signed(opA) >>> opB[4:0];
			OR:      aluResult = opA | opB;
			AND:     aluResult = opA & opB;
			default: aluResult = '0; // sltu and friends are not supported
		endcase
	end

	assign exMemNext = '{
		memRead:   idEx.ctrl.memRead,
		memWrite:  idEx.ctrl.memWrite,
		memToReg:  idEx.ctrl.memToReg,
		regWrite:  idEx.ctrl.regWrite,
		aluResult: aluResult,
		storeData: rs2Fwd,
		rd:        idEx.rd
	};

	pipeReg #(
		.T(exMem_t)
	) u_exMemReg (
		.clk   (clk),
		.rst_n (rst_n),
		.stall (1'b0),
		.bubble(1'b0),
		.d     (exMemNext),
		.q     (exMem)
	);

endmodule

`default_nettype wire

// ==== logic/decodeStage.sv ====
// Instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module decodeStage
	import rvPkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  ifId_t    ifId,
	input  fwdSrc_t  meFwd,
	input  fwdSrc_t  wb,
	input  regAddr_t exRd,
	input  ctrl_t    exCtrl,
	input  logic     meLoad,  // Load sitting in memory stage
	output logic     stall,
	output logic     redirect,
	output word_t    redirectPc,
	output idEx_t    idEx
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	regAddr_t   rs1;
	regAddr_t   rs2;
	regAddr_t   rd;
	ctrl_t      ctrl;
	word_t      imm;
	word_t      rs1Data;
	word_t      rs2Data;
	word_t      brOp1;
	word_t      brOp2;
	logic       isBranch;
	logic       usesRs2;
	logic       condMet;
	logic       exHitsRs1;
	logic       exHitsRs2;
	logic       loadUse;
	logic       branchExHaz;
	logic       branchMeHaz;
	idEx_t      idExNext;

	assign opcode   = ifId.inst[6:0];
	assign funct3   = ifId.inst[14:12];
	assign rs1      = ifId.inst[19:15];
	assign rs2      = ifId.inst[24:20];
	assign rd       = ifId.inst[11:7];
	assign isBranch = (opcode == OP_BRANCH);
	assign usesRs2  = (opcode == OP_RTYPE) || (opcode == OP_STORE) || isBranch;

	// ====================================================================
	// Control and immediates
	// ====================================================================
	always_comb begin
		ctrl       = '0;
		ctrl.aluOp = ADD;
		case (opcode)
			OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluOp_e'({ifId.inst[30], funct3});
			end
			OP_ITYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				// Bit 30 only means something for srai
				ctrl.aluOp    = aluOp_e'({ifId.inst[30] && (funct3 == 3'b101), funct3});
			end
			OP_LOAD: begin
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			OP_STORE: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
			end
			default: ctrl.aluOp = ADD; // Branches and unknown opcodes write nothing
		endcase
	end

	always_comb begin
		case (opcode)
			OP_ITYPE: begin
				if ((funct3 == 3'b001) || (funct3 == 3'b101)) begin
					imm = {27'b0, ifId.inst[24:20]}; // Shift amount
				end else begin
					imm = {{20{ifId.inst[31]}}, ifId.inst[31:20]};
				end
			end
			OP_LOAD:   imm = {{20{ifId.inst[31]}}, ifId.inst[31:20]};
			OP_STORE:  imm = {{20{ifId.inst[31]}}, ifId.inst[31:25], ifId.inst[11:7]};
			OP_BRANCH: imm = {{19{ifId.inst[31]}}, ifId.inst[31], ifId.inst[7],
			                  ifId.inst[30:25], ifId.inst[11:8], 1'b0};
			default:   imm = '0;
		endcase
	end

	regFile u_regFile (
		.clk    (clk),
		.rst_n  (rst_n),
		.rs1    (rs1),
		.rs2    (rs2),
		.wb     (wb),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data)
	);

	// ====================================================================
	// Branch resolution
	// ====================================================================
	// Writeback data already arrives through the register file bypass
	assign brOp1 = (meFwd.regWrite && (meFwd.rd != '0) && (meFwd.rd == rs1)) ?
	               meFwd.data : rs1Data;
	assign brOp2 = (meFwd.regWrite && (meFwd.rd != '0) && (meFwd.rd == rs2)) ?
	               meFwd.data : rs2Data;

	always_comb begin
		case (funct3)
			3'b000:  condMet = (brOp1 == brOp2); // beq
			3'b001:  condMet = (brOp1 != brOp2); // bne
			default: condMet = 1'b0;
		endcase
	end

	assign redirect   = isBranch && condMet && !stall;
	assign redirectPc = ifId.pc + imm;

	// ====================================================================
	// Hazards
	// ====================================================================
	assign exHitsRs1   = (exRd != '0) && (exRd == rs1);
	assign exHitsRs2   = (exRd != '0) && (exRd == rs2) && usesRs2;
	assign loadUse     = exCtrl.memRead && (exHitsRs1 || exHitsRs2);
	assign branchExHaz = isBranch && exCtrl.regWrite && (exHitsRs1 || exHitsRs2);
	// Memory stage holds only the address of a load
	assign branchMeHaz = isBranch && meLoad && (meFwd.rd != '0) &&
	                     ((meFwd.rd == rs1) || (meFwd.rd == rs2));
	assign stall       = loadUse || branchExHaz || branchMeHaz;

	assign idExNext = '{ctrl: ctrl, rs1Data: rs1Data, rs2Data: rs2Data, imm: imm,
	                    rs1: rs1, rs2: rs2, rd: rd};

	pipeReg #(
		.T(idEx_t)
	) u_idExReg (
		.clk   (clk),
		.rst_n (rst_n),
		.stall (1'b0),
		.bubble(stall),  // Empty slot while decode waits
		.d     (idExNext),
		.q     (idEx)
	);

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module regFile
	import rvPkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  regAddr_t rs1,
	input  regAddr_t rs2,
	input  fwdSrc_t  wb,
	output word_t    rs1Data,
	output word_t    rs2Data
);

	word_t regs [0:31]; // Entry 0 is never written

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.regWrite && (wb.rd != '0)) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// Write-first so decode sees this cycle's writeback
	always_comb begin
		rs1Data = regs[rs1];
		rs2Data = regs[rs2];
		if (wb.regWrite && (wb.rd != '0) && (wb.rd == rs1)) begin
			rs1Data = wb.data;
		end
		if (wb.regWrite && (wb.rd != '0) && (wb.rd == rs2)) begin
			rs2Data = wb.data;
		end
	end

endmodule

`default_nettype wire

// ==== logic/fetchStage.sv ====
// Instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetchStage
	import rvPkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  stall,
	input  logic  redirect,
	input  word_t redirectPc,
	input  word_t imemData,
	output word_t imemAddr,
	output ifId_t ifId
);

	word_t pc;
	word_t nextPc;
	ifId_t ifIdNext;

	// Hold has priority over a redirect
	always_comb begin
		if (stall) begin
			nextPc = pc;
		end else if (redirect) begin
			nextPc = redirectPc;
		end else begin
			nextPc = pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else begin
			pc <= nextPc;
		end
	end

	assign imemAddr = pc;
	assign ifIdNext = '{pc: pc, inst: imemData};

	// Wrong-path instruction becomes a NOP on redirect
	pipeReg #(
		.T       (ifId_t),
		.resetVal(IFID_RESET)
	) u_ifIdReg (
		.clk   (clk),
		.rst_n (rst_n),
		.stall (stall),
		.bubble(redirect),
		.d     (ifIdNext),
		.q     (ifId)
	);

endmodule

`default_nettype wire

// ==== logic/pipeReg.sv ====
// Pipeline stage register
`timescale 1ns/1ps
`default_nettype none

module pipeReg
	import rvPkg::*;
#(
	parameter type T        = word_t,
	parameter T    resetVal = T'(0)
) (
	input  logic clk,
	input  logic rst_n,
	input  logic stall,  // Keep current contents
	input  logic bubble, // Load the empty payload
	input  T     d,
	output T     q
);

	always_ff @(posedge clk) begin
		if (!rst_n || bubble) begin
			q <= resetVal;
		end else if (!stall) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// ==== logic/rvPkg.sv ====
// RV32I pipeline shared definitions
`default_nettype none

package rvPkg;

	// ====================================================================
	// Widths and encodings
	// ====================================================================
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] regAddr_t;

	localparam word_t NOP_INST = 32'h0000_0013; // addi x0, x0, 0

	localparam logic [6:0] OP_RTYPE  = 7'b0110011;
	localparam logic [6:0] OP_ITYPE  = 7'b0010011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

	// Bit 3 is funct7 bit 5, low bits are funct3
	typedef enum logic [3:0] {
		ADD = 4'b0000,
		SUB = 4'b1000,
		SLL = 4'b0001,
		SLT = 4'b0010,
		XOR = 4'b0100,
		SRL = 4'b0101,
		SRA = 4'b1101,
		OR  = 4'b0110,
		AND = 4'b0111
	} aluOp_e;

	typedef struct packed {
		logic   memRead;
		logic   memWrite;
		logic   memToReg;
		logic   aluSrc;   // Immediate as operand B
		logic   regWrite;
		aluOp_e aluOp;
	} ctrl_t;

	// ====================================================================
	// Stage payloads
	// ====================================================================
	typedef struct packed {
		word_t pc;
		word_t inst;
	} ifId_t;

	localparam ifId_t IFID_RESET = '{pc: '0, inst: NOP_INST};

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    rs1Data;
		word_t    rs2Data;
		word_t    imm;
		regAddr_t rs1;
		regAddr_t rs2;
		regAddr_t rd;
	} idEx_t;

	typedef struct packed {
		logic     memRead;
		logic     memWrite;
		logic     memToReg;
		logic     regWrite;
		word_t    aluResult; // Also the data address
		word_t    storeData;
		regAddr_t rd;
	} exMem_t;

	typedef struct packed {
		logic     memToReg;
		logic     regWrite;
		word_t    aluResult;
		word_t    loadData;
		regAddr_t rd;
	} memWb_t;

	// A later-stage writer offered for forwarding
	typedef struct packed {
		logic     regWrite;
		regAddr_t rd;
		word_t    data;
	} fwdSrc_t;

	// Newest writer first, x0 never forwards
	function automatic word_t forwardOperand(
		regAddr_t rs,
		word_t    regVal,
		fwdSrc_t  me,
		fwdSrc_t  wb
	);
		if (me.regWrite && (me.rd != '0) && (me.rd == rs)) begin
			return me.data;
		end
		if (wb.regWrite && (wb.rd != '0) && (wb.rd == rs)) begin
			return wb.data;
		end
		return regVal;
	endfunction

endpackage

`default_nettype wire
